//--- source/fir_macros.svh
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// data path and AXI-Lite widths
`define FIR_DATA_W 32
`define FIR_ADDR_W 12

// tap limit, also the depth of both RAMs
`define FIR_MAX_TAPS 32
`define FIR_IDX_W 5

// register map
`define FIR_REG_AP_CTRL 12'h000
`define FIR_REG_TAP_NUM 12'h014
// tap k at base + 4k, window ends at 0x0ff
`define FIR_REG_TAP_BASE 12'h080

`endif

//--- source/fir_pkg.sv
`include "fir_macros.svh"

package fir_pkg;

  // run state seen through ap_ctrl
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2
  } ctrl_state_e;

  // compute block, one sample at a time
  typedef enum logic [1:0] {
    WAIT_IN = 2'd0,
    MAC     = 2'd1,
    FLUSH   = 2'd2,
    OUT     = 2'd3
  } dp_state_e;

  typedef logic [`FIR_DATA_W-1:0] word_t;
  typedef logic [`FIR_IDX_W-1:0] idx_t;

endpackage

//--- source/fir_core_if.sv
`timescale 1ns/1ps
`include "fir_macros.svh"

interface fir_core_if ();

  // run control from the register block
  logic                 start;
  logic [`FIR_IDX_W:0]  tap_num;
  logic                 last_done;

  // tap RAM read port, owned by the datapath while busy
  fir_pkg::idx_t        tap_addr;
  fir_pkg::word_t       tap_data;

  modport ctrl (
    output start,
    output tap_num,
    output tap_data,
    input  last_done,
    input  tap_addr
  );

  modport dp (
    input  start,
    input  tap_num,
    input  tap_data,
    output last_done,
    output tap_addr
  );

endinterface

//--- source/fir_ram.sv
`timescale 1ns/1ps
`include "fir_macros.svh"

module fir_ram (
  input  logic           axis_clk,
  input  logic           en,
  input  logic           we,
  input  fir_pkg::idx_t  addr,
  input  fir_pkg::word_t din,
  output fir_pkg::word_t dout
);

  fir_pkg::word_t mem [`FIR_MAX_TAPS];

  // write-first, read data one cycle after addr
  always_ff @(posedge axis_clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= din;
        dout      <= din;
      end else begin
        dout <= mem[addr];
      end
    end
  end

endmodule

//--- source/fir_ctrl_regs.sv
`timescale 1ns/1ps
`include "fir_macros.svh"

module fir_ctrl_regs (
  input  logic                   axis_clk,
  input  logic                   axis_rst_n,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [`FIR_ADDR_W-1:0] awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  logic [`FIR_DATA_W-1:0] wdata,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [`FIR_ADDR_W-1:0] araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output logic [`FIR_DATA_W-1:0] rdata,
  fir_core_if.ctrl               core
);

  fir_pkg::ctrl_state_e state_q;
  fir_pkg::ctrl_state_e state_d;
  logic [`FIR_IDX_W:0]  tap_num_q;
  logic                 start_q;
  logic                 rvalid_q;
  logic                 rd_tap_q;
  fir_pkg::word_t       rdata_q;
  fir_pkg::word_t       rd_val;
  logic                 busy;
  logic                 wr_fire;
  logic                 rd_fire;
  logic                 ap_go;
  logic                 ap_rd;
  logic                 tap_wr;
  logic                 tap_rd;
  logic                 tap_en;
  logic                 tap_we;
  fir_pkg::idx_t        tap_addr;
  fir_pkg::word_t       tap_dout;

  function automatic logic in_tap_win(input logic [`FIR_ADDR_W-1:0] a);
    return (a & ~(`FIR_ADDR_W'(4 * `FIR_MAX_TAPS - 1))) == `FIR_REG_TAP_BASE;
  endfunction

  assign busy    = (state_q == fir_pkg::BUSY);
  assign wr_fire = awvalid & wvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  // reads wait for writes and for the previous response
  assign arready = arvalid & ~wr_fire & ~rvalid_q;
  assign rd_fire = arvalid & arready;

  assign ap_go  = wr_fire & (awaddr == `FIR_REG_AP_CTRL) & wdata[0] & ~busy;
  assign ap_rd  = rd_fire & (araddr == `FIR_REG_AP_CTRL);
  assign tap_wr = wr_fire & in_tap_win(awaddr) & ~busy;
  assign tap_rd = rd_fire & in_tap_win(araddr) & ~busy;

  always_comb begin
    state_d = state_q;
    case (state_q)
      fir_pkg::IDLE: begin
        if (ap_go) begin
          state_d = fir_pkg::BUSY;
        end
      end
      fir_pkg::BUSY: begin
        if (core.last_done) begin
          state_d = fir_pkg::DONE;
        end
      end
      fir_pkg::DONE: begin
        // reading ap_ctrl clears done
        if (ap_go) begin
          state_d = fir_pkg::BUSY;
        end else if (ap_rd) begin
          state_d = fir_pkg::IDLE;
        end
      end
      default: begin
        state_d = fir_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state_q   <= fir_pkg::IDLE;
      start_q   <= 1'b0;
      tap_num_q <= '0;
      rvalid_q  <= 1'b0;
      rd_tap_q  <= 1'b0;
    end else begin
      state_q  <= state_d;
      start_q  <= ap_go;
      rd_tap_q <= tap_rd;
      if (wr_fire && (awaddr == `FIR_REG_TAP_NUM) && !busy) begin
        tap_num_q <= wdata[`FIR_IDX_W:0];
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // register read value, tap reads and unmapped give all ones
  always_comb begin
    rd_val = '1;
    if (araddr == `FIR_REG_AP_CTRL) begin
      rd_val = {{(`FIR_DATA_W-3){1'b0}}, ~busy, state_q == fir_pkg::DONE, start_q};
    end else if (araddr == `FIR_REG_TAP_NUM) begin
      rd_val = {{(`FIR_DATA_W-`FIR_IDX_W-1){1'b0}}, tap_num_q};
    end
  end

  // tap data arrives with rvalid, then held here
  always_ff @(posedge axis_clk) begin
    if (rd_fire) begin
      rdata_q <= rd_val;
    end else if (rd_tap_q) begin
      rdata_q <= tap_dout;
    end
  end

  assign rvalid = rvalid_q;
  assign rdata  = rd_tap_q ? tap_dout : rdata_q;

  // tap RAM port goes to the datapath for the whole run
  always_comb begin
    if (busy) begin
      tap_en   = 1'b1;
      tap_we   = 1'b0;
      tap_addr = core.tap_addr;
    end else begin
      tap_en   = tap_wr | tap_rd;
      tap_we   = tap_wr;
      tap_addr = tap_wr ? awaddr[`FIR_IDX_W+1:2] : araddr[`FIR_IDX_W+1:2];
    end
  end

  fir_ram i_tap_ram (
    .axis_clk (axis_clk),
    .en       (tap_en),
    .we       (tap_we),
    .addr     (tap_addr),
    .din      (wdata),
    .dout     (tap_dout)
  );

  assign core.start    = start_q;
  assign core.tap_num  = tap_num_q;
  assign core.tap_data = tap_dout;

endmodule

//--- source/fir_datapath.sv
`timescale 1ns/1ps
`include "fir_macros.svh"

module fir_datapath (
  input  logic           axis_clk,
  input  logic           axis_rst_n,
  input  logic           ss_tvalid,
  input  fir_pkg::word_t ss_tdata,
  input  logic           ss_tlast,
  output logic           ss_tready,
  output logic           sm_tvalid,
  input  logic           sm_tready,
  output fir_pkg::word_t sm_tdata,
  output logic           sm_tlast,
  fir_core_if.dp         core
);

  fir_pkg::dp_state_e  state_q;
  logic                running_q;
  fir_pkg::idx_t       wr_ptr_q;
  fir_pkg::idx_t       k_q;
  logic [`FIR_IDX_W:0] samp_cnt_q;
  logic                s1_vld_q;
  logic                s1_zero_q;
  logic                p_vld_q;
  logic                last_q;
  fir_pkg::word_t      prod_q;
  fir_pkg::word_t      acc_q;
  fir_pkg::word_t      data_dout;
  fir_pkg::idx_t       data_addr;
  logic                data_en;
  logic                in_fire;
  logic                out_fire;
  logic                k_last;

  assign ss_tready = running_q & (state_q == fir_pkg::WAIT_IN);
  assign sm_tvalid = (state_q == fir_pkg::OUT);
  assign in_fire   = ss_tvalid & ss_tready;
  assign out_fire  = sm_tvalid & sm_tready;
  // also ends the walk at once when tap_num is zero
  assign k_last    = ({1'b0, k_q} + 6'd1) >= core.tap_num;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state_q    <= fir_pkg::WAIT_IN;
      running_q  <= 1'b0;
      wr_ptr_q   <= '0;
      samp_cnt_q <= '0;
      k_q        <= '0;
      s1_vld_q   <= 1'b0;
      p_vld_q    <= 1'b0;
    end else begin
      s1_vld_q <= (state_q == fir_pkg::MAC);
      p_vld_q  <= s1_vld_q;
      if (core.start) begin
        state_q    <= fir_pkg::WAIT_IN;
        running_q  <= 1'b1;
        wr_ptr_q   <= '0;
        samp_cnt_q <= '0;
        k_q        <= '0;
      end else begin
        case (state_q)
          fir_pkg::WAIT_IN: begin
            if (in_fire) begin
              state_q <= fir_pkg::MAC;
              k_q     <= '0;
              if (samp_cnt_q != `FIR_MAX_TAPS) begin
                samp_cnt_q <= samp_cnt_q + 1'b1;
              end
            end
          end
          fir_pkg::MAC: begin
            k_q <= k_q + 1'b1;
            if (k_last) begin
              state_q <= fir_pkg::FLUSH;
            end
          end
          fir_pkg::FLUSH: begin
            // wait for read and multiply stages to empty
            if (!s1_vld_q && !p_vld_q) begin
              state_q <= fir_pkg::OUT;
            end
          end
          fir_pkg::OUT: begin
            if (out_fire) begin
              state_q  <= fir_pkg::WAIT_IN;
              wr_ptr_q <= wr_ptr_q + 1'b1;
              if (last_q) begin
                running_q <= 1'b0;
              end
            end
          end
          default: begin
            state_q <= fir_pkg::WAIT_IN;
          end
        endcase
      end
    end
  end

  // samples older than the run contribute zero
  always_ff @(posedge axis_clk) begin
    s1_zero_q <= ({1'b0, k_q} >= samp_cnt_q);
    prod_q    <= s1_zero_q ? '0 : data_dout * core.tap_data;
    if (in_fire) begin
      last_q <= ss_tlast;
      acc_q  <= '0;
    end else if (p_vld_q) begin
      acc_q <= acc_q + prod_q;
    end
  end

  // ring buffer, sample n-k sits k slots behind the write pointer
  assign data_en   = in_fire | (state_q == fir_pkg::MAC);
  assign data_addr = (state_q == fir_pkg::MAC) ? wr_ptr_q - k_q : wr_ptr_q;

  fir_ram i_data_ram (
    .axis_clk (axis_clk),
    .en       (data_en),
    .we       (in_fire),
    .addr     (data_addr),
    .din      (ss_tdata),
    .dout     (data_dout)
  );

  assign core.tap_addr  = k_q;
  assign core.last_done = out_fire & last_q;

  // acc stays put in OUT, so it is the output word
  assign sm_tdata = acc_q;
  assign sm_tlast = sm_tvalid & last_q;

endmodule

//--- source/fir_top.sv
`timescale 1ns/1ps
`include "fir_macros.svh"

module fir_top (
  input  logic                   axis_clk,
  input  logic                   axis_rst_n,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [`FIR_ADDR_W-1:0] awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  logic [`FIR_DATA_W-1:0] wdata,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [`FIR_ADDR_W-1:0] araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output logic [`FIR_DATA_W-1:0] rdata,
  input  logic                   ss_tvalid,
  input  logic [`FIR_DATA_W-1:0] ss_tdata,
  input  logic                   ss_tlast,
  output logic                   ss_tready,
  output logic                   sm_tvalid,
  input  logic                   sm_tready,
  output logic [`FIR_DATA_W-1:0] sm_tdata,
  output logic                   sm_tlast
);

  fir_core_if core_if ();

  // AXI-Lite side, ap_ctrl and tap storage
  fir_ctrl_regs i_ctrl (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .core       (core_if.ctrl)
  );

  // stream side and MAC
  fir_datapath i_dp (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .ss_tvalid  (ss_tvalid),
    .ss_tdata   (ss_tdata),
    .ss_tlast   (ss_tlast),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .core       (core_if.dp)
  );

endmodule

//--- dv/fir_checker.sv
`timescale 1ns/1ps
`include "fir_macros.svh"

module fir_checker (
  input  logic                   axis_clk,
  input  logic                   axis_rst_n,
  input  logic                   sm_tvalid,
  input  logic                   sm_tready,
  input  logic [`FIR_DATA_W-1:0] sm_tdata,
  input  logic                   sm_tlast,
  input  logic                   rvalid,
  input  logic                   rready,
  input  logic [`FIR_DATA_W-1:0] rdata,
  input  logic                   rd_chk,
  input  logic [`FIR_DATA_W-1:0] rd_exp,
  input  logic [`FIR_DATA_W-1:0] exp_data [`FIR_MAX_TAPS],
  input  logic                   exp_last [`FIR_MAX_TAPS],
  input  int                     exp_num,
  input  logic                   report_req,
  output int                     err_cnt,
  output int                     out_cnt
);

  logic                   hold_q;
  logic [`FIR_DATA_W-1:0] hold_data;
  logic                   reported;

  always @(posedge axis_clk or negedge axis_rst_n) begin : watch
    int errs;
    errs = 0;
    if (!axis_rst_n) begin
      err_cnt  <= 0;
      out_cnt  <= 0;
      hold_q   <= 1'b0;
      reported <= 1'b0;
    end else begin
      // stalled output must stay put
      if (hold_q && !sm_tvalid) begin
        $display("output %0d was withdrawn before it was accepted", out_cnt);
        errs++;
      end else if (hold_q && sm_tdata != hold_data) begin
        $display("Fail sm_tdata changed under stall: got %h held %h", sm_tdata, hold_data);
        errs++;
      end
      if (sm_tvalid && sm_tready) begin
        if (out_cnt >= exp_num) begin
          $display("extra output beyond the expected %0d", exp_num);
          errs++;
        end else begin
          if (sm_tdata != exp_data[out_cnt]) begin
            $display("Fail sm_tdata output %0d: got %h expected %h",
                     out_cnt, sm_tdata, exp_data[out_cnt]);
            errs++;
          end
          if (sm_tlast != exp_last[out_cnt]) begin
            $display("Fail sm_tlast output %0d: got %h expected %h",
                     out_cnt, sm_tlast, exp_last[out_cnt]);
            errs++;
          end
        end
        out_cnt <= out_cnt + 1;
      end
      hold_q    <= sm_tvalid && !sm_tready;
      hold_data <= sm_tdata;
      if (rvalid && rready && rd_chk && rdata != rd_exp) begin
        $display("Fail rdata: got %h expected %h", rdata, rd_exp);
        errs++;
      end
      if (report_req && !reported) begin
        if (out_cnt != exp_num) begin
          $display("only %0d of %0d outputs arrived", out_cnt, exp_num);
          errs++;
        end
        $display("checker: %0d outputs, %0d errors", out_cnt, err_cnt + errs);
        reported <= 1'b1;
      end
      err_cnt <= err_cnt + errs;
    end
  end

endmodule

//--- dv/tb_fir.sv
`timescale 1ns/1ps
`include "fir_macros.svh"

module tb_fir;

  logic                   axis_clk = 1'b0;
  logic                   axis_rst_n;
  logic                   awvalid, wvalid, arvalid, rready;
  logic [`FIR_ADDR_W-1:0] awaddr, araddr;
  logic [`FIR_DATA_W-1:0] wdata, ss_tdata, rd_exp, rdata, sm_tdata;
  logic                   ss_tvalid, ss_tlast, sm_tready, rd_chk, report_req;
  logic                   awready, wready, arready, rvalid, ss_tready, sm_tvalid, sm_tlast;
  logic [`FIR_DATA_W-1:0] taps [`FIR_MAX_TAPS];
  logic [`FIR_DATA_W-1:0] samples [`FIR_MAX_TAPS];
  logic                   in_last [`FIR_MAX_TAPS];
  logic [`FIR_DATA_W-1:0] exp_data [`FIR_MAX_TAPS];
  logic                   exp_last [`FIR_MAX_TAPS];
  logic [`FIR_ADDR_W-1:0] unmapped;
  logic [`FIR_DATA_W-1:0] unmapped_val;
  int                     ntaps, nsamp, err_cnt, out_cnt, cyc, limit;
  integer                 seed = 32'h04e3acdd;

  always #50 axis_clk = ~axis_clk;

  fir_top i_dut (.*);

  fir_checker i_chk (
    .exp_num (nsamp),
    .*
  );

  // back-pressure on the output stream
  always @(negedge axis_clk) begin
    if (axis_rst_n) sm_tready = ($random(seed) & 3) != 0;
  end

  task automatic end_run(input bit timed_out);
    report_req = 1'b1;
    @(negedge axis_clk);
    @(negedge axis_clk);
    if (timed_out || err_cnt != 0) begin
      $display("Verification failed");
    end else begin
      $display("Verification passed");
    end
    $finish;
  endtask

  always @(posedge axis_clk) begin
    cyc = cyc + 1;
    if (cyc == limit) begin
      $display("timeout after %0d cycles, run did not finish", cyc);
      end_run(1'b1);
    end
  end

  task automatic axil_write(input logic [`FIR_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge axis_clk);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    do @(posedge axis_clk); while (!(awready && wready));
    @(negedge axis_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic axil_read(input logic [`FIR_ADDR_W-1:0] addr, input logic [31:0] exp);
    @(negedge axis_clk);
    arvalid = 1'b1;
    araddr  = addr;
    rd_exp  = exp;
    rd_chk  = 1'b1;
    do @(posedge axis_clk); while (!arready);
    @(negedge axis_clk);
    arvalid = 1'b0;
    do @(posedge axis_clk); while (!rvalid);
    @(negedge axis_clk);
    rd_chk = 1'b0;
  endtask

  task automatic load_stim();
    int    fd;
    int    code;
    int    nh;
    string line;
    nh = 0;
    fd = $fopen("dv/fir_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/fir_stim.txt");
      end_run(1'b1);
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code == 0 || line.len() < 2 || line[0] == "#") continue;
        case (line[0])
          "n": code = $sscanf(line, "n %h", ntaps);
          "h": begin
            // taps come in order, tap 0 first
            code = $sscanf(line, "h %h", taps[nh]);
            nh++;
          end
          "u": code = $sscanf(line, "u %h %h", unmapped, unmapped_val);
          "s": begin
            code = $sscanf(line, "s %h %h %h", samples[nsamp], in_last[nsamp],
                           exp_data[nsamp]);
            exp_last[nsamp] = in_last[nsamp];
            nsamp++;
          end
          default: $display("unknown line in stim file: %s", line);
        endcase
      end
      $fclose(fd);
    end
  endtask

  initial begin
    {awvalid, wvalid, arvalid, ss_tvalid, ss_tlast, sm_tready, rd_chk, report_req} = '0;
    {awaddr, araddr, wdata, ss_tdata, rd_exp} = '0;
    rready     = 1'b1;
    axis_rst_n = 1'b0;
    cyc        = 0;
    nsamp      = 0;
    limit      = 100000;
    load_stim();
    limit   = nsamp * (ntaps + 8) + 500;
    repeat (16) @(negedge axis_clk);
    axis_rst_n = 1'b1;
    // register setup and readback
    axil_read(`FIR_REG_AP_CTRL, 32'h4);
    axil_write(`FIR_REG_TAP_NUM, ntaps);
    for (int k = 0; k < ntaps; k++) begin
      axil_write(`FIR_ADDR_W'(`FIR_REG_TAP_BASE + 4 * k), taps[k]);
    end
    for (int k = 0; k < ntaps; k++) begin
      axil_read(`FIR_ADDR_W'(`FIR_REG_TAP_BASE + 4 * k), taps[k]);
    end
    axil_read(`FIR_REG_TAP_NUM, ntaps);
    axil_read(unmapped, unmapped_val);
    axil_write(`FIR_REG_AP_CTRL, 32'h1);
    for (int i = 0; i < nsamp; i++) begin
      @(negedge axis_clk);
      ss_tvalid = 1'b1;
      ss_tdata  = samples[i];
      ss_tlast  = in_last[i];
      do @(posedge axis_clk); while (!ss_tready);
      @(negedge axis_clk);
      ss_tvalid = 1'b0;
      if (i == 3) begin
        // tap port belongs to the datapath mid-run
        axil_read(`FIR_REG_TAP_BASE, 32'hffffffff);
        axil_write(`FIR_REG_TAP_BASE, 32'h63);
      end
    end
    while (out_cnt < nsamp) @(negedge axis_clk);
    axil_read(`FIR_REG_AP_CTRL, 32'h6);
    axil_read(`FIR_REG_AP_CTRL, 32'h4);
    axil_read(`FIR_REG_TAP_BASE, taps[0]);
    end_run(1'b0);
  end

endmodule

//--- compile.f
+incdir+source
source/fir_pkg.sv
source/fir_core_if.sv
source/fir_ram.sv
source/fir_ctrl_regs.sv
source/fir_datapath.sv
source/fir_top.sv
dv/fir_checker.sv
dv/tb_fir.sv

//--- Makefile
# Verilator build and run for the FIR testbench
VERILATOR ?= verilator
TOP       ?= tb_fir
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Verification failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/fir_stim.txt
# n <tap count> | h <coefficient> | u <unmapped addr> <read value>
# s <sample> <tlast> <expected output>, all fields hex
n 05
h 00000003
h 00000001
h 00000004
h 00000001
h 00000005
u 040 ffffffff
s 00000002 0 00000006
s 00000007 0 00000017
s 00000001 0 00000012
s 00000008 0 00000037
s 00000002 0 00000023
s 00000008 0 0000005e
s 00000001 0 00000020
s 00000008 1 00000063
